/* Bender.yml */
package:
  name: bp_static

sources:
  - src/isa_pkg.sv
  - src/pred_pkg.sv
  - src/dec_if.sv
  - src/exe_if.sv
  - src/bp_decode.sv
  - src/bp_execute.sv
  - src/bp_result.sv
  - src/bp_top.sv
  - target: test
    files:
      - test/bp_checker.sv
      - test/tb_bp_top.sv

/* project.f */
src/isa_pkg.sv
src/pred_pkg.sv
src/dec_if.sv
src/exe_if.sv
src/bp_decode.sv
src/bp_execute.sv
src/bp_result.sv
src/bp_top.sv
test/bp_checker.sv
test/tb_bp_top.sv

/* src/bp_decode.sv */
// Decode stage that classifies the fetched word and picks its immediate
`timescale 1ns/10ps

module bp_decode #(
  parameter bit CompressedEn = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            fetch_valid_i,
  input  pred_pkg::addr_t fetch_pc_i,
  input  isa_pkg::instr_u fetch_rdata_i,
  dec_if.dec              dec
);
  import isa_pkg::*;
  import pred_pkg::*;

  logic     is_b;
  logic     is_j;
  logic     is_c;
  logic     is_cb;
  logic     is_cj;
  addr_t    imm_b;
  addr_t    imm_j;
  addr_t    imm_cb;
  addr_t    imm_cj;
  addr_t    imm_d;
  br_kind_e kind_d;

  // Low two bits other than 11 mark a compressed word
  assign is_c = CompressedEn && (fetch_rdata_i.comp.c_op != 2'b11);

  // Uncompressed control flow by major opcode
  assign is_b = fetch_rdata_i.full.opcode == opc_branch_c;
  assign is_j = fetch_rdata_i.full.opcode == opc_jal_c;

  // Compressed control flow, quadrant 01 only
  assign is_cb = is_c && (fetch_rdata_i.comp.c_op == c_quad1_c) &&
                 ((fetch_rdata_i.comp.c_funct3 == cf3_beqz_c) ||
                  (fetch_rdata_i.comp.c_funct3 == cf3_bnez_c));
  assign is_cj = is_c && (fetch_rdata_i.comp.c_op == c_quad1_c) &&
                 ((fetch_rdata_i.comp.c_funct3 == cf3_j_c) ||
                  (fetch_rdata_i.comp.c_funct3 == cf3_jal_c));

  // B-type offset with sign from bit 31
  assign imm_b = {{19{fetch_rdata_i.full.imm_hi[6]}}, fetch_rdata_i.full.imm_hi[6],
                  fetch_rdata_i.full.imm_lo[0], fetch_rdata_i.full.imm_hi[5:0],
                  fetch_rdata_i.full.imm_lo[4:1], 1'b0};

  // J-type offset whose bits 19:12 span rs1 and funct3
  assign imm_j = {{11{fetch_rdata_i.full.imm_hi[6]}}, fetch_rdata_i.full.imm_hi[6],
                  fetch_rdata_i.full.rs1, fetch_rdata_i.full.funct3,
                  fetch_rdata_i.full.rs2[0], fetch_rdata_i.full.imm_hi[5:0],
                  fetch_rdata_i.full.rs2[4:1], 1'b0};

  // CB offset with c_body index equal to instruction bit minus 2
  assign imm_cb = {{23{fetch_rdata_i.comp.c_body[10]}}, fetch_rdata_i.comp.c_body[10],
                   fetch_rdata_i.comp.c_body[4:3], fetch_rdata_i.comp.c_body[0],
                   fetch_rdata_i.comp.c_body[9:8], fetch_rdata_i.comp.c_body[2:1], 1'b0};

  // CJ offset
  assign imm_cj = {{20{fetch_rdata_i.comp.c_body[10]}}, fetch_rdata_i.comp.c_body[10],
                   fetch_rdata_i.comp.c_body[6], fetch_rdata_i.comp.c_body[8:7],
                   fetch_rdata_i.comp.c_body[4], fetch_rdata_i.comp.c_body[5],
                   fetch_rdata_i.comp.c_body[0], fetch_rdata_i.comp.c_body[9],
                   fetch_rdata_i.comp.c_body[3:1], 1'b0};

  // Kind and offset select with zero offset for non-control words
  always_comb begin
    kind_d = br_none;
    imm_d  = '0;
    if (is_j) begin
      kind_d = br_jump;
      imm_d  = imm_j;
    end else if (is_b) begin
      kind_d = br_branch;
      imm_d  = imm_b;
    end else if (is_cj) begin
      kind_d = br_c_jump;
      imm_d  = imm_cj;
    end else if (is_cb) begin
      kind_d = br_c_branch;
      imm_d  = imm_cb;
    end
  end

  // Stage register whose payload loads only on a strobe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec.valid      <= 1'b0;
      dec.pc         <= '0;
      dec.kind       <= br_none;
      dec.imm        <= '0;
      dec.compressed <= 1'b0;
    end else begin
      dec.valid <= fetch_valid_i;
      if (fetch_valid_i) begin
        dec.pc         <= fetch_pc_i;
        dec.kind       <= kind_d;
        dec.imm        <= imm_d;
        dec.compressed <= is_c;
      end
    end
  end

endmodule

/* src/bp_execute.sv */
// Execute stage with target addition and static taken decision
`timescale 1ns/10ps

module bp_execute (
  input  logic clk_i,
  input  logic rst_n_i,
  dec_if.exe   dec,
  exe_if.exe   exe
);
  import pred_pkg::*;

  addr_t target_d;
  logic  taken_d;

  // PC-relative target equal to pc when the offset is zero
  assign target_d = dec.pc + dec.imm;

  // Jumps always taken and branches only backwards
  always_comb begin
    unique case (dec.kind)
      br_jump, br_c_jump:     taken_d = 1'b1;
      br_branch, br_c_branch: taken_d = dec.imm[addr_w-1];
      default:                taken_d = 1'b0;
    endcase
  end

  // Stage register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exe.valid      <= 1'b0;
      exe.pc         <= '0;
      exe.taken      <= 1'b0;
      exe.target     <= '0;
      exe.compressed <= 1'b0;
    end else begin
      exe.valid <= dec.valid;
      if (dec.valid) begin
        exe.pc         <= dec.pc;
        exe.taken      <= taken_d;
        exe.target     <= target_d;
        exe.compressed <= dec.compressed;
      end
    end
  end

endmodule

/* src/bp_result.sv */
// Result stage with next fetch PC select and output register
`timescale 1ns/10ps

module bp_result #(
  parameter bit CompressedEn = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  exe_if.res              exe,
  output logic            predict_valid_o,
  output logic            predict_taken_o,
  output pred_pkg::addr_t predict_pc_o,
  output pred_pkg::addr_t next_pc_o
);
  import pred_pkg::*;

  addr_t fall_pc;
  addr_t next_pc_d;

  // Halfword step only for compressed words
  assign fall_pc   = exe.pc + ((CompressedEn && exe.compressed) ? step_comp_c : step_full_c);
  assign next_pc_d = exe.taken ? exe.target : fall_pc;

  // Output register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      predict_valid_o <= 1'b0;
      predict_taken_o <= 1'b0;
      predict_pc_o    <= '0;
      next_pc_o       <= '0;
    end else begin
      predict_valid_o <= exe.valid;
      if (exe.valid) begin
        predict_taken_o <= exe.taken;
        // Target shown even when not taken
        predict_pc_o    <= exe.target;
        next_pc_o       <= next_pc_d;
      end
    end
  end

endmodule

/* src/bp_top.sv */
// Static branch predictor top level
// Decode, execute and result stages, three cycles of latency
`timescale 1ns/10ps

module bp_top #(
  parameter bit CompressedEn = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // Fetched word with its PC
  input  logic            fetch_valid_i,
  input  pred_pkg::addr_t fetch_pc_i,
  input  logic [31:0]     fetch_rdata_i,

  // Prediction
  output logic            predict_valid_o,
  output logic            predict_taken_o,
  output pred_pkg::addr_t predict_pc_o,
  output pred_pkg::addr_t next_pc_o
);

  // Stage buses
  dec_if dec_bus ();
  exe_if exe_bus ();

  // Classification and offset
  bp_decode #(
    .CompressedEn (CompressedEn)
  ) u_decode (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_rdata_i (fetch_rdata_i),
    .dec           (dec_bus.dec)
  );

  // Target and taken
  bp_execute u_execute (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dec     (dec_bus.exe),
    .exe     (exe_bus.exe)
  );

  // Next PC and outputs
  bp_result #(
    .CompressedEn (CompressedEn)
  ) u_result (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .exe             (exe_bus.res),
    .predict_valid_o (predict_valid_o),
    .predict_taken_o (predict_taken_o),
    .predict_pc_o    (predict_pc_o),
    .next_pc_o       (next_pc_o)
  );

endmodule

/* src/dec_if.sv */
// Decode-to-execute bus
// One decoded word per valid strobe
`timescale 1ns/10ps

interface dec_if;
  import pred_pkg::*;

  // Fields meaningful only while valid is high
  logic     valid;
  logic     compressed;
  addr_t    pc;
  addr_t    imm;
  br_kind_e kind;

  // Decode side drives
  modport dec (
    output valid, pc, kind, imm, compressed
  );

  // Execute side reads
  modport exe (
    input valid, pc, kind, imm, compressed
  );

endinterface

/* src/exe_if.sv */
// Execute-to-result bus
// One resolved prediction per valid strobe
`timescale 1ns/10ps

interface exe_if;
  import pred_pkg::*;

  // Fields meaningful only while valid is high
  logic  valid;
  logic  taken;
  logic  compressed;
  addr_t pc;
  addr_t target;

  // Execute side drives
  modport exe (
    output valid, pc, taken, target, compressed
  );

  // Result side reads
  modport res (
    input valid, pc, taken, target, compressed
  );

endinterface

/* src/isa_pkg.sv */
// Instruction encoding constants for the fetch-path predictor
// Fetch word union with full 32-bit and compressed 16-bit views
package isa_pkg;

  // Major opcodes of the uncompressed control-flow instructions
  localparam logic [6:0] opc_branch_c = 7'b1100011;
  localparam logic [6:0] opc_jal_c    = 7'b1101111;

  // Compressed quadrant holding C.J, C.JAL, C.BEQZ, C.BNEZ
  localparam logic [1:0] c_quad1_c = 2'b01;

  // Compressed funct3 values in quadrant 01
  localparam logic [2:0] cf3_jal_c  = 3'b001;
  localparam logic [2:0] cf3_j_c    = 3'b101;
  localparam logic [2:0] cf3_beqz_c = 3'b110;
  localparam logic [2:0] cf3_bnez_c = 3'b111;

  // Uncompressed view split along the B/J immediate boundaries
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } instr_full_s;

  // Compressed view with only the low halfword meaningful
  typedef struct packed {
    logic [15:0] unused;
    logic [2:0]  c_funct3;
    logic [10:0] c_body;
    logic [1:0]  c_op;
  } instr_c_s;

  // Same fetch word, decoded both ways
  typedef union packed {
    instr_full_s full;
    instr_c_s    comp;
  } instr_u;

endpackage

/* src/pred_pkg.sv */
// Predictor-internal types
// Address width, address type and control-flow kind
package pred_pkg;

  // Fetch address width
  localparam int unsigned addr_w = 32;

  // PCs, targets and sign-extended offsets
  typedef logic [addr_w-1:0] addr_t;

  // Control-flow class of a fetched word
  typedef enum logic [2:0] {
    br_none     = 3'd0,
    br_branch   = 3'd1,
    br_jump     = 3'd2,
    br_c_branch = 3'd3,
    br_c_jump   = 3'd4
  } br_kind_e;

  // Step from a PC to the next word
  localparam addr_t step_full_c = addr_t'(4);
  localparam addr_t step_comp_c = addr_t'(2);

endpackage

/* test/bp_checker.sv */
// Reference model and scoreboard for the static branch predictor
// Expected results wait in a queue for the fixed three-cycle latency
`timescale 1ns/10ps

module bp_checker #(
  parameter bit CompressedEn = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            fetch_valid_i,
  input  pred_pkg::addr_t fetch_pc_i,
  input  logic [31:0]     fetch_rdata_i,
  input  logic            predict_valid_i,
  input  logic            predict_taken_i,
  input  pred_pkg::addr_t predict_pc_i,
  input  pred_pkg::addr_t next_pc_i,
  output int              error_count_o,
  output int              check_count_o,
  output int              pending_o
);
  import isa_pkg::*;
  import pred_pkg::*;

  localparam int latency_c = 3;

  // One expected prediction and its due sample cycle
  typedef struct packed {
    logic [31:0] due;
    addr_t       pc;
    logic        taken;
    addr_t       target;
    addr_t       next_pc;
  } expect_s;

  expect_s     exp_q[$];
  logic [31:0] cycle = '0;
  int          errors = 0;
  int          checks = 0;
  int          pending = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;
  assign pending_o     = pending;

  // Static prediction rules taken straight from the instruction bits
  function automatic expect_s predict_word(input addr_t pc, input logic [31:0] w);
    expect_s    e;
    logic       comp;
    logic       quad1;
    logic       jump;
    logic       branch;
    logic [2:0] f3;
    addr_t      imm;
    comp   = CompressedEn && (w[1:0] != 2'b11);
    quad1  = comp && (w[1:0] == c_quad1_c);
    f3     = w[15:13];
    jump   = 1'b0;
    branch = 1'b0;
    imm    = '0;
    if (w[6:0] == opc_jal_c) begin
      jump = 1'b1;
      imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end else if (w[6:0] == opc_branch_c) begin
      branch = 1'b1;
      imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    end else if (quad1 && (f3 == cf3_j_c || f3 == cf3_jal_c)) begin
      jump = 1'b1;
      imm  = {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    end else if (quad1 && (f3 == cf3_beqz_c || f3 == cf3_bnez_c)) begin
      branch = 1'b1;
      imm    = {{24{w[12]}}, w[6:5], w[2], w[11:10], w[4:3], 1'b0};
    end
    e.due     = '0;
    e.pc      = pc;
    e.taken   = jump || (branch && imm[31]);
    e.target  = pc + imm;
    // Halfword step for compressed words
    e.next_pc = e.taken ? e.target : pc + (comp ? 32'd2 : 32'd4);
    return e;
  endfunction

  task automatic compare_field(input string what, input addr_t got, input addr_t want,
                               input addr_t pc);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED %0t: %s for pc %h is %h, expected %h", $time, what, pc, got, want);
    end
  endtask

  // Sampled on the falling edge away from the driving edge
  always @(negedge clk_i) begin : watch
    expect_s e;
    if (!rst_n_i) begin
      exp_q.delete();
      if (predict_valid_i !== 1'b0) begin
        errors++;
        $display("Prediction strobe not low during reset at %0t", $time);
      end
    end else begin
      cycle = cycle + 1;
      // Due slot already passed without a strobe
      while (exp_q.size() != 0 && exp_q[0].due < cycle) begin
        e = exp_q.pop_front();
        errors++;
        $display("Missing prediction strobe for pc %h at %0t", e.pc, $time);
      end
      if (predict_valid_i === 1'b1) begin
        if (exp_q.size() == 0 || exp_q[0].due != cycle) begin
          errors++;
          $display("Prediction strobe with no fetch due at %0t", $time);
        end else begin
          e = exp_q.pop_front();
          compare_field("taken", addr_t'(predict_taken_i), addr_t'(e.taken), e.pc);
          compare_field("target", predict_pc_i, e.target, e.pc);
          compare_field("next pc", next_pc_i, e.next_pc, e.pc);
        end
      end
      if (fetch_valid_i === 1'b1) begin
        e     = predict_word(fetch_pc_i, fetch_rdata_i);
        e.due = cycle + latency_c;
        exp_q.push_back(e);
      end
    end
    pending = exp_q.size();
  end

endmodule

/* test/tb_bp_top.sv */
// Testbench top for the static branch predictor
// Clock, reset, seeded random fetch stream, DUT and checker
`timescale 1ns/10ps

module tb_bp_top;
  import isa_pkg::*;
  import pred_pkg::*;

  localparam int drain_limit = 20;
  localparam int reset_limit = 5;

  logic        clk_i;
  logic        rst_n_i;
  logic        fetch_valid_i;
  addr_t       fetch_pc_i;
  logic [31:0] fetch_rdata_i;
  logic        predict_valid_o;
  logic        predict_taken_o;
  addr_t       predict_pc_o;
  addr_t       next_pc_o;
  int          error_count;
  int          check_count;
  int          pending;
  int          seed = 32'had1c;
  int          tests_ok = 0;
  int          tests_bad = 0;
  bit          timed_out = 1'b0;

  bp_top #(
    .CompressedEn (1'b1)
  ) UUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_pc_i      (fetch_pc_i),
    .fetch_rdata_i   (fetch_rdata_i),
    .predict_valid_o (predict_valid_o),
    .predict_taken_o (predict_taken_o),
    .predict_pc_o    (predict_pc_o),
    .next_pc_o       (next_pc_o)
  );

  bp_checker #(
    .CompressedEn (1'b1)
  ) u_checker (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_pc_i      (fetch_pc_i),
    .fetch_rdata_i   (fetch_rdata_i),
    .predict_valid_i (predict_valid_o),
    .predict_taken_i (predict_taken_o),
    .predict_pc_i    (predict_pc_o),
    .next_pc_i       (next_pc_o),
    .error_count_o   (error_count),
    .check_count_o   (check_count),
    .pending_o       (pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Random word biased to class 0 JAL, 1 branch, 2 compressed control or 3 other
  function automatic logic [31:0] make_word(input int cls);
    logic [31:0] r;
    r = $random(seed);
    case (cls)
      0: r[6:0] = opc_jal_c;
      1: r[6:0] = opc_branch_c;
      2: begin
        case (r[17:16])
          2'd0:    r[15:13] = cf3_j_c;
          2'd1:    r[15:13] = cf3_jal_c;
          2'd2:    r[15:13] = cf3_beqz_c;
          default: r[15:13] = cf3_bnez_c;
        endcase
        r[1:0] = c_quad1_c;
      end
      default: begin
        // Steer off the control opcodes
        if (r[6:0] == opc_jal_c || r[6:0] == opc_branch_c) r[2] = ~r[2];
        // Quadrant 01 kept to funct3 000 or 010
        if (r[1:0] == c_quad1_c) r[15:13] = {1'b0, r[14], 1'b0};
      end
    endcase
    return r;
  endfunction

  // Class 4 mixes all classes and dense gives a strobe every cycle
  task automatic run_test(input string name, input int cls, input int cycles, input bit dense);
    int errs_before;
    int wait_cnt;
    int word_cls;
    errs_before = error_count;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_i);
      word_cls = (cls == 4) ? ($unsigned($random(seed)) % 4) : cls;
      fetch_valid_i <= dense ? 1'b1 : (($random(seed) & 3) != 0);
      fetch_pc_i    <= $random(seed) & 32'hffff_fffe;
      fetch_rdata_i <= make_word(word_cls);
    end
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    wait_cnt = 0;
    do begin
      @(posedge clk_i);
      wait_cnt++;
    end while (pending != 0 && wait_cnt < drain_limit);
    if (pending != 0) begin
      timed_out = 1'b1;
      $display("Test %s timed out with %0d predictions outstanding", name, pending);
    end
    if (pending == 0 && error_count == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed, %0d errors", name, error_count - errs_before);
    end
  endtask

  initial begin
    int wait_cnt;
    rst_n_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pc_i    = '0;
    fetch_rdata_i = '0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Prediction strobe idle once reset is released
    wait_cnt = 0;
    do begin
      @(posedge clk_i);
      wait_cnt++;
    end while (predict_valid_o !== 1'b0 && wait_cnt < reset_limit);
    if (predict_valid_o !== 1'b0) begin
      timed_out = 1'b1;
      $display("Prediction strobe never settled low after reset release");
    end
    if (!timed_out) run_test("jal", 0, 60, 1'b0);
    if (!timed_out) run_test("branch", 1, 80, 1'b0);
    if (!timed_out) run_test("compressed", 2, 80, 1'b0);
    if (!timed_out) run_test("non_control", 3, 60, 1'b0);
    if (!timed_out) run_test("back_to_back", 4, 50, 1'b1);
    $display("tests ok %0d, failed %0d, checks %0d, errors %0d",
             tests_ok, tests_bad, check_count, error_count);
    if (timed_out || tests_bad != 0 || error_count != 0) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule
